// ==== hdl/soc_io_pkg.sv ====
// ==========================================================
// soc_io shared definitions
// bus request structs, the bus word union, the address map
// and the random unit feedback taps
// ==========================================================
package soc_io_pkg;

	// wide bus request, one 64-bit transfer
	typedef struct packed {
		logic        we;
		logic [7:0]  sel;
		logic [31:0] adr;
		logic [63:0] dat;
	} bus_req_t;

	// narrow bus request, one 32-bit transfer
	// adr bits 2..0 rebuilt by the bridge from the lane selects
	typedef struct packed {
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} narrow_req_t;

	// 64-bit bus word, whole or split into lanes
	typedef union packed {
		logic [63:0] whole;
		struct packed {
			logic [31:0] hi;
			logic [31:0] lo;
		} lane;
	} bus_word_u;

	// ==========================================================
	// address map
	// ==========================================================
	// adr[31:20]
	localparam logic [11:0] SCR_REGION = 12'hFF4;
	// adr[31:4]
	localparam logic [27:0] LED_REGION = 28'hFFDC060;
	localparam logic [27:0] RND_REGION = 28'hFFDC0C0;
	// adr[31:16]
	localparam logic [15:0] VID_REGION = 16'hFFD0;

	// unmapped reads see this
	localparam logic [63:0] FILL_WORD = {4{16'h0080}};

	// galois feedback mask
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

endpackage

// ==== hdl/bus_fabric.sv ====
// ==========================================================
// bus fabric
// address decode and steering to the targets, the LED/switch
// port and filler answers for unmapped addresses
// ==========================================================
module bus_fabric
	import soc_io_pkg::*;
(
	input  logic        clk20,
	input  logic        reset_i,
	input  bus_req_t    bus_req_i,
	input  logic        bus_req_stb_i,
	output logic        bus_ack_o,
	output logic [63:0] bus_rdata_o,
	input  logic [7:0]  sw_i,
	output logic [7:0]  led_o,
	output bus_req_t    tgt_req_o,
	output logic        scr_req_o,
	input  logic        scr_ack_i,
	input  logic [63:0] scr_rdata_i,
	output logic        rnd_req_o,
	input  logic        rnd_ack_i,
	input  logic [63:0] rnd_rdata_i,
	output logic        vid_req_o,
	input  logic        vid_ack_i,
	input  logic [63:0] vid_rdata_i
);

	logic        cs_scr;
	logic        cs_led;
	logic        cs_rnd;
	logic        cs_vid;
	// led port and unmapped space, answered here
	logic        local_req;
	logic        local_ack;
	logic [63:0] local_rdata;

	// ==========================================================
	// decode
	// ==========================================================
	assign cs_scr = bus_req_i.adr[31:20] == SCR_REGION;
	assign cs_led = bus_req_i.adr[31:4] == LED_REGION;
	assign cs_rnd = bus_req_i.adr[31:4] == RND_REGION;
	assign cs_vid = bus_req_i.adr[31:16] == VID_REGION;

	// one req per target, only while the master holds req
	assign tgt_req_o = bus_req_i;
	assign scr_req_o = bus_req_stb_i & cs_scr;
	assign rnd_req_o = bus_req_stb_i & cs_rnd;
	assign vid_req_o = bus_req_stb_i & cs_vid;
	assign local_req = bus_req_stb_i & ~(cs_scr | cs_rnd | cs_vid);

	// ==========================================================
	// local slave
	// ==========================================================
	always_ff @(posedge clk20)
	begin
		if (reset_i)
		begin
			local_ack <= 1'b0;
			led_o     <= 8'h00;
		end
		else
		begin
			local_ack <= local_req;
			// led write lands with the rising ack
			if (local_req && !local_ack && cs_led && bus_req_i.we && bus_req_i.sel[0])
				led_o <= bus_req_i.dat[7:0];
		end
	end

	// read word captured as ack rises
	always_ff @(posedge clk20)
	begin
		if (local_req && !local_ack)
			local_rdata <= cs_led ? {8{sw_i}} : FILL_WORD;
	end

	// ==========================================================
	// ack and read data merge
	// ==========================================================
	// acks are exclusive, so the one that is high picks the data
	// and the merge holds even after the address moves on
	assign bus_ack_o = scr_ack_i | rnd_ack_i | vid_ack_i | local_ack;

	always_comb
	begin
		if (scr_ack_i)
			bus_rdata_o = scr_rdata_i;
		else if (rnd_ack_i)
			bus_rdata_o = rnd_rdata_i;
		else if (vid_ack_i)
			bus_rdata_o = vid_rdata_i;
		else
			bus_rdata_o = local_rdata;
	end

	// only one target busy at a time, counting a lingering ack
	a_one_target: assert property (@(posedge clk20) disable iff (reset_i)
		$onehot0({scr_req_o | scr_ack_i, rnd_req_o | rnd_ack_i,
			vid_req_o | vid_ack_i, local_req | local_ack}))
		else $error("more than one bus target active");

endmodule

// ==== hdl/scratch_ram.sv ====
// ==========================================================
// scratch RAM
// byte-writable 64-bit memory on the wide bus
// ==========================================================
module scratch_ram
	import soc_io_pkg::*;
#(
	parameter int SCR_ADDR_W = 10
)
(
	input  logic        clk20,
	input  logic        reset_i,
	input  logic        req_i,
	input  bus_req_t    req_s_i,
	output logic        ack_o,
	output logic [63:0] rdata_o
);

	logic [63:0]           mem [2**SCR_ADDR_W];
	logic [SCR_ADDR_W-1:0] idx;
	// first cycle of a transfer
	logic                  start;

	// word index, wraps modulo depth
	assign idx   = req_s_i.adr[SCR_ADDR_W+2:3];
	assign start = req_i & ~ack_o;

	always_ff @(posedge clk20)
	begin
		if (reset_i)
			ack_o <= 1'b0;
		else
			ack_o <= req_i;
	end

	always_ff @(posedge clk20)
	begin
		if (start && req_s_i.we)
		begin
			// byte lanes
			for (int b = 0; b < 8; b++)
				if (req_s_i.sel[b])
					mem[idx][b*8 +: 8] <= req_s_i.dat[b*8 +: 8];
		end
		else if (start)
			rdata_o <= mem[idx];
	end

	a_ack_follows_req: assert property (@(posedge clk20) disable iff (reset_i)
		$rose(ack_o) |-> req_i)
		else $error("scratch ack rose without a request");

endmodule

// ==== hdl/prng_unit.sv ====
// ==========================================================
// random number unit
// seedable 32-bit galois LFSR, one step per bus read
// ==========================================================
module prng_unit
	import soc_io_pkg::*;
(
	input  logic        clk20,
	input  logic        reset_i,
	input  logic        req_i,
	input  bus_req_t    req_s_i,
	output logic        ack_o,
	output logic [63:0] rdata_o
);

	logic [31:0] state;
	logic [31:0] next_state;
	logic [31:0] seed;
	logic        start;
	// seed register sits at offset 0
	logic        ofs0;

	assign start = req_i & ~ack_o;
	assign ofs0  = ~req_s_i.adr[3];

	// shift right, fold taps in when bit 0 drops out
	assign next_state = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);

	// an all-zero state would lock up
	assign seed = (req_s_i.dat[31:0] == 32'h0) ? 32'h1 : req_s_i.dat[31:0];

	always_ff @(posedge clk20)
	begin
		if (reset_i)
		begin
			ack_o <= 1'b0;
			state <= 32'h1;
		end
		else
		begin
			ack_o <= req_i;
			if (start && req_s_i.we && ofs0)
				state <= seed;
			else if (start && !req_s_i.we)
				state <= next_state;
		end
	end

	// current value in both lanes
	always_ff @(posedge clk20)
	begin
		if (start && !req_s_i.we)
			rdata_o <= {2{state}};
	end

endmodule

// ==== hdl/io_bridge.sv ====
// ==========================================================
// I/O bridge
// turns each 64-bit transfer into one or two 32-bit
// transfers on the narrow bus, lo lane first
// ==========================================================
module io_bridge
	import soc_io_pkg::*;
(
	input  logic        clk20,
	input  logic        reset_i,
	input  logic        req_i,
	input  bus_req_t    req_s_i,
	output logic        ack_o,
	output logic [63:0] rdata_o,
	output logic        n_req_o,
	output narrow_req_t n_req_s_o,
	input  logic        n_ack_i,
	input  logic [31:0] n_rdata_i
);

	// fsm states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_XFER = 2'd1;
	localparam logic [1:0] ST_DROP = 2'd2;
	localparam logic [1:0] ST_ACK  = 2'd3;

	logic [1:0] state;
	// lane of the narrow transfer in flight
	logic       cur_hi;
	logic       lo_act;
	logic       hi_act;
	logic [3:0] lane_sel;
	logic [1:0] lane_ofs;
	bus_word_u  wr_word;
	bus_word_u  rd_word;

	assign lo_act        = |req_s_i.sel[3:0];
	assign hi_act        = |req_s_i.sel[7:4];
	assign wr_word.whole = req_s_i.dat;
	assign lane_sel      = cur_hi ? req_s_i.sel[7:4] : req_s_i.sel[3:0];

	// byte offset from lowest set select
	always_comb
	begin
		if (lane_sel[0])
			lane_ofs = 2'd0;
		else if (lane_sel[1])
			lane_ofs = 2'd1;
		else if (lane_sel[2])
			lane_ofs = 2'd2;
		else
			lane_ofs = 2'd3;
	end

	// master holds the wide struct until our ack, so this stays stable
	always_comb
	begin
		n_req_s_o.we  = req_s_i.we;
		n_req_s_o.sel = lane_sel;
		n_req_s_o.adr = {req_s_i.adr[31:3], cur_hi, lane_ofs};
		n_req_s_o.dat = cur_hi ? wr_word.lane.hi : wr_word.lane.lo;
	end

	// ==========================================================
	// sequencing
	// ==========================================================
	always_ff @(posedge clk20)
	begin
		if (reset_i)
		begin
			state   <= ST_IDLE;
			cur_hi  <= 1'b0;
			n_req_o <= 1'b0;
			ack_o   <= 1'b0;
		end
		else
		begin
			case (state)
			ST_IDLE:
				if (req_i && (lo_act || hi_act))
				begin
					// skip lo lane when it has no selects
					cur_hi  <= ~lo_act;
					n_req_o <= 1'b1;
					state   <= ST_XFER;
				end
				else if (req_i)
				begin
					// nothing selected, answer at once
					ack_o <= 1'b1;
					state <= ST_ACK;
				end
			ST_XFER:
				if (n_ack_i)
				begin
					n_req_o <= 1'b0;
					state   <= ST_DROP;
				end
			ST_DROP:
				// wait out the narrow ack before anything else
				if (!n_ack_i && !cur_hi && hi_act)
				begin
					cur_hi  <= 1'b1;
					n_req_o <= 1'b1;
					state   <= ST_XFER;
				end
				else if (!n_ack_i)
				begin
					ack_o <= 1'b1;
					state <= ST_ACK;
				end
			default:
				if (!req_i)
				begin
					ack_o <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// single lane fills both halves, dual lane each its own
	always_ff @(posedge clk20)
	begin
		if (state == ST_XFER && n_ack_i)
		begin
			if (!cur_hi || !lo_act)
				rd_word.lane.lo <= n_rdata_i;
			if (cur_hi || !hi_act)
				rd_word.lane.hi <= n_rdata_i;
		end
	end

	assign rdata_o = rd_word.whole;

	// four-phase on the narrow side, ack seen low on the edge req went up
	a_narrow_handshake: assert property (@(posedge clk20) disable iff (reset_i)
		$rose(n_req_o) |-> !$past(n_ack_i))
		else $error("narrow req raised while previous ack still high");

endmodule

// ==== hdl/video_reg_file.sv ====
// ==========================================================
// video control registers
// byte-writable 32-bit register bank on the narrow bus
// ==========================================================
module video_reg_file
	import soc_io_pkg::*;
#(
	parameter int VREG_COUNT = 16
)
(
	input  logic        clk20,
	input  logic        reset_i,
	input  logic        req_i,
	input  narrow_req_t req_s_i,
	output logic        ack_o,
	output logic [31:0] rdata_o
);

	localparam int IDX_W = $clog2(VREG_COUNT);

	logic [31:0]      regs [VREG_COUNT];
	logic [IDX_W-1:0] idx;
	logic             start;

	// register index, wraps modulo count
	assign idx   = req_s_i.adr[IDX_W+1:2];
	assign start = req_i & ~ack_o;

	always_ff @(posedge clk20)
	begin
		if (reset_i)
		begin
			ack_o <= 1'b0;
			for (int r = 0; r < VREG_COUNT; r++)
				regs[r] <= 32'h0;
		end
		else
		begin
			ack_o <= req_i;
			if (start && req_s_i.we)
				for (int b = 0; b < 4; b++)
					if (req_s_i.sel[b])
						regs[idx][b*8 +: 8] <= req_s_i.dat[b*8 +: 8];
		end
	end

	// read data held until the next read
	always_ff @(posedge clk20)
	begin
		if (start && !req_s_i.we)
			rdata_o <= regs[idx];
	end

endmodule

// ==== hdl/soc_io_top.sv ====
// ==========================================================
// soc_io top level
// fabric plus scratch RAM, random unit and the video bridge
// ==========================================================
module soc_io_top
	import soc_io_pkg::*;
#(
	parameter int SCR_ADDR_W = 10,
	parameter int VREG_COUNT = 16
)
(
	input  logic        clk20,
	input  logic        reset_i,
	input  bus_req_t    bus_req_i,
	input  logic        bus_req_stb_i,
	output logic        bus_ack_o,
	output logic [63:0] bus_rdata_o,
	input  logic [7:0]  sw_i,
	output logic [7:0]  led_o
);

	// request broadcast to every target
	bus_req_t tgt_req;

	logic        scr_req;
	logic        scr_ack;
	logic [63:0] scr_rdata;
	logic        rnd_req;
	logic        rnd_ack;
	logic [63:0] rnd_rdata;
	logic        vid_req;
	logic        vid_ack;
	logic [63:0] vid_rdata;

	// narrow side of the bridge
	logic        n_req;
	narrow_req_t n_req_s;
	logic        n_ack;
	logic [31:0] n_rdata;

	bus_fabric u_bus_fabric
	(
		.clk20         (clk20),
		.reset_i       (reset_i),
		.bus_req_i     (bus_req_i),
		.bus_req_stb_i (bus_req_stb_i),
		.bus_ack_o     (bus_ack_o),
		.bus_rdata_o   (bus_rdata_o),
		.sw_i          (sw_i),
		.led_o         (led_o),
		.tgt_req_o     (tgt_req),
		.scr_req_o     (scr_req),
		.scr_ack_i     (scr_ack),
		.scr_rdata_i   (scr_rdata),
		.rnd_req_o     (rnd_req),
		.rnd_ack_i     (rnd_ack),
		.rnd_rdata_i   (rnd_rdata),
		.vid_req_o     (vid_req),
		.vid_ack_i     (vid_ack),
		.vid_rdata_i   (vid_rdata)
	);

	scratch_ram #(.SCR_ADDR_W(SCR_ADDR_W)) u_scratch_ram
	(
		.clk20   (clk20),
		.reset_i (reset_i),
		.req_i   (scr_req),
		.req_s_i (tgt_req),
		.ack_o   (scr_ack),
		.rdata_o (scr_rdata)
	);

	prng_unit u_prng_unit
	(
		.clk20   (clk20),
		.reset_i (reset_i),
		.req_i   (rnd_req),
		.req_s_i (tgt_req),
		.ack_o   (rnd_ack),
		.rdata_o (rnd_rdata)
	);

	io_bridge u_io_bridge
	(
		.clk20     (clk20),
		.reset_i   (reset_i),
		.req_i     (vid_req),
		.req_s_i   (tgt_req),
		.ack_o     (vid_ack),
		.rdata_o   (vid_rdata),
		.n_req_o   (n_req),
		.n_req_s_o (n_req_s),
		.n_ack_i   (n_ack),
		.n_rdata_i (n_rdata)
	);

	video_reg_file #(.VREG_COUNT(VREG_COUNT)) u_video_reg_file
	(
		.clk20   (clk20),
		.reset_i (reset_i),
		.req_i   (n_req),
		.req_s_i (n_req_s),
		.ack_o   (n_ack),
		.rdata_o (n_rdata)
	);

endmodule

// ==== testbench/soc_io_tb.sv ====
// ==========================================================
// soc_io testbench
// table-driven four-phase bus master with reference models
// for scratch, LED, random unit and video registers
// ==========================================================
module soc_io_tb
	import soc_io_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int SCR_DEPTH  = 1024;
	localparam int VREG_COUNT = 16;
	// expected values straight from the address map rules
	localparam logic [63:0] FILL_EXP = {4{16'h0080}};
	localparam logic [31:0] TAPS_EXP = 32'h80200003;

	// expected-read kinds
	localparam logic [2:0] K_SCR = 3'd0;
	localparam logic [2:0] K_LED = 3'd1;
	localparam logic [2:0] K_RND = 3'd2;
	localparam logic [2:0] K_VID = 3'd3;
	localparam logic [2:0] K_MAP = 3'd4;

	typedef struct packed {
		logic        we;
		logic [7:0]  sel;
		logic [31:0] adr;
		logic [63:0] dat;
		logic [2:0]  kind;
	} entry_t;

	logic        clk20;
	logic        reset_i;
	bus_req_t    bus_req_i;
	logic        bus_req_stb_i;
	logic        bus_ack_o;
	logic [63:0] bus_rdata_o;
	logic [7:0]  sw_i;
	logic [7:0]  led_o;

	integer      seed;
	entry_t      table_q [$];
	logic        table_ready;

	// reference models
	logic [63:0] scr_model [SCR_DEPTH];
	logic [31:0] vid_model [VREG_COUNT];
	logic [7:0]  led_model;
	logic [31:0] lfsr_model;

	soc_io_top #(.SCR_ADDR_W(10), .VREG_COUNT(VREG_COUNT)) u_soc_io_top
	(
		.clk20         (clk20),
		.reset_i       (reset_i),
		.bus_req_i     (bus_req_i),
		.bus_req_stb_i (bus_req_stb_i),
		.bus_ack_o     (bus_ack_o),
		.bus_rdata_o   (bus_rdata_o),
		.sw_i          (sw_i),
		.led_o         (led_o)
	);

	always #(CLK_PERIOD / 2) clk20 = ~clk20;

	// ==========================================================
	// helpers
	// ==========================================================
	function logic [63:0] rand_word();
		rand_word = {$random(seed), $random(seed)};
	endfunction

	// selected bytes of new over old
	function automatic logic [63:0] merge_bytes(logic [63:0] old_w, logic [63:0] new_w,
		logic [7:0] sel);
		logic [63:0] res;
		res = old_w;
		for (int b = 0; b < 8; b++)
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		return res;
	endfunction

	// galois step, the bit shifted out gates the tap mask
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		logic [31:0] mask;
		mask = {32{s[0]}} & TAPS_EXP;
		return {1'b0, s[31:1]} ^ mask;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		if (got !== exp)
		begin
			$display("Mismatch %s exp=%h got=%h", name, exp, got);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic add_entry(input logic we, input logic [7:0] sel, input logic [31:0] adr,
		input logic [63:0] dat, input logic [2:0] kind);
		entry_t e;
		e.we   = we;
		e.sel  = sel;
		e.adr  = adr;
		e.dat  = dat;
		e.kind = kind;
		table_q.push_back(e);
	endtask

	// four-phase master, samples on the falling edge
	task automatic run_transfer(input bus_req_t r, output logic [63:0] rd);
		@(negedge clk20);
		// ack must be low before a new req
		check_value("bus_ack_o", 64'h0, {63'h0, bus_ack_o});
		@(posedge clk20);
		bus_req_i     <= r;
		bus_req_stb_i <= 1'b1;
		do
			@(negedge clk20);
		while (bus_ack_o !== 1'b1);
		rd = bus_rdata_o;
		@(posedge clk20);
		bus_req_stb_i <= 1'b0;
		do
			@(negedge clk20);
		while (bus_ack_o !== 1'b0);
	endtask

	// ==========================================================
	// stimulus table
	// ==========================================================
	task automatic build_table();
		// scratch, full then partial writes, index wrap at 0x2000
		add_entry(1'b1, 8'hFF, 32'hFF40_0000, rand_word(), K_SCR);
		add_entry(1'b1, 8'hFF, 32'hFF40_0008, rand_word(), K_SCR);
		add_entry(1'b1, 8'h0F, 32'hFF40_0000, rand_word(), K_SCR);
		add_entry(1'b1, 8'hA5, 32'hFF40_0008, rand_word(), K_SCR);
		add_entry(1'b0, 8'hFF, 32'hFF40_0000, 64'h0, K_SCR);
		add_entry(1'b0, 8'hFF, 32'hFF40_0008, 64'h0, K_SCR);
		add_entry(1'b1, 8'hFF, 32'hFF40_1FF8, rand_word(), K_SCR);
		add_entry(1'b1, 8'h80, 32'hFF40_1FF8, rand_word(), K_SCR);
		add_entry(1'b0, 8'hFF, 32'hFF40_1FF8, 64'h0, K_SCR);
		add_entry(1'b0, 8'hFF, 32'hFF40_2000, 64'h0, K_SCR);
		// led port, second write has no byte 0 select
		add_entry(1'b1, 8'h01, 32'hFFDC_0600, rand_word(), K_LED);
		add_entry(1'b1, 8'hFE, 32'hFFDC_0600, rand_word(), K_LED);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0600, 64'h0, K_LED);
		// random unit from reset, seeded, then zero seed
		add_entry(1'b0, 8'hFF, 32'hFFDC_0C00, 64'h0, K_RND);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0C00, 64'h0, K_RND);
		add_entry(1'b1, 8'hFF, 32'hFFDC_0C00, rand_word(), K_RND);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0C00, 64'h0, K_RND);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0C00, 64'h0, K_RND);
		add_entry(1'b1, 8'hFF, 32'hFFDC_0C00, rand_word() & 64'hFFFF_FFFF_0000_0000, K_RND);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0C00, 64'h0, K_RND);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0C00, 64'h0, K_RND);
		// bridge, single lane in either half
		add_entry(1'b1, 8'h0F, 32'hFFD0_0000, rand_word(), K_VID);
		add_entry(1'b1, 8'hF0, 32'hFFD0_0008, rand_word(), K_VID);
		add_entry(1'b1, 8'h06, 32'hFFD0_0010, rand_word(), K_VID);
		add_entry(1'b0, 8'h0F, 32'hFFD0_0000, 64'h0, K_VID);
		add_entry(1'b0, 8'hF0, 32'hFFD0_0008, 64'h0, K_VID);
		add_entry(1'b0, 8'h0F, 32'hFFD0_0010, 64'h0, K_VID);
		// bridge, both lanes
		add_entry(1'b1, 8'hFF, 32'hFFD0_0018, rand_word(), K_VID);
		add_entry(1'b1, 8'h3C, 32'hFFD0_0018, rand_word(), K_VID);
		add_entry(1'b0, 8'hFF, 32'hFFD0_0018, 64'h0, K_VID);
		add_entry(1'b0, 8'hFF, 32'hFFD0_0000, 64'h0, K_VID);
		add_entry(1'b0, 8'hFF, 32'hFFD0_0040, 64'h0, K_VID);
		// unmapped, including a hole next to the led port
		add_entry(1'b0, 8'hFF, 32'h1000_0000, 64'h0, K_MAP);
		add_entry(1'b1, 8'hFF, 32'h1000_0000, rand_word(), K_MAP);
		add_entry(1'b0, 8'hFF, 32'hFFDC_0700, 64'h0, K_MAP);
	endtask

	// ==========================================================
	// apply one entry and update the models
	// ==========================================================
	task automatic apply_entry(input entry_t e);
		bus_req_t    r;
		logic [63:0] rd;
		logic [63:0] pair;
		int          si;
		int          vi;
		r.we  = e.we;
		r.sel = e.sel;
		r.adr = e.adr;
		r.dat = e.dat;
		run_transfer(r, rd);
		case (e.kind)
		K_SCR:
		begin
			si = (e.adr >> 3) % SCR_DEPTH;
			if (e.we)
				scr_model[si] = merge_bytes(scr_model[si], e.dat, e.sel);
			else
				check_value("bus_rdata_o", scr_model[si], rd);
		end
		K_LED:
		begin
			if (e.we && e.sel[0])
				led_model = e.dat[7:0];
			if (e.we)
				check_value("led_o", {56'h0, led_model}, {56'h0, led_o});
			else
				check_value("bus_rdata_o", {8{sw_i}}, rd);
		end
		K_RND:
		begin
			if (e.we)
				lfsr_model = (e.dat[31:0] == 32'h0) ? 32'h1 : e.dat[31:0];
			else
			begin
				check_value("bus_rdata_o", {2{lfsr_model}}, rd);
				lfsr_model = lfsr_step(lfsr_model);
			end
		end
		K_VID:
		begin
			// lo lane at the even register, hi lane at the next
			vi   = ((e.adr >> 3) % (VREG_COUNT / 2)) * 2;
			pair = {vid_model[vi+1], vid_model[vi]};
			if (e.we)
			begin
				pair            = merge_bytes(pair, e.dat, e.sel);
				vid_model[vi]   = pair[31:0];
				vid_model[vi+1] = pair[63:32];
			end
			else if (!(|e.sel[7:4]))
				check_value("bus_rdata_o", {2{pair[31:0]}}, rd);
			else if (!(|e.sel[3:0]))
				check_value("bus_rdata_o", {2{pair[63:32]}}, rd);
			else
				check_value("bus_rdata_o", pair, rd);
		end
		default:
			if (!e.we)
				check_value("bus_rdata_o", FILL_EXP, rd);
		endcase
	endtask

	// ==========================================================
	// main sequence
	// ==========================================================
	initial
	begin
		seed          = 32'hbbf9;
		table_ready   = 1'b0;
		clk20         = 1'b0;
		reset_i       = 1'b1;
		bus_req_i     = '0;
		bus_req_stb_i = 1'b0;
		sw_i          = $random(seed);
		led_model     = 8'h00;
		lfsr_model    = 32'h1;
		for (int r = 0; r < VREG_COUNT; r++)
			vid_model[r] = 32'h0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clk20);
		reset_i <= 1'b0;
		// leds cleared by reset
		@(negedge clk20);
		check_value("led_o", 64'h0, {56'h0, led_o});
		foreach (table_q[i])
			apply_entry(table_q[i]);
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// generous budget of 40 cycles per table entry
	initial
	begin
		wait (table_ready);
		#(table_q.size() * 40 * CLK_PERIOD);
		$display("timeout, a bus transfer never completed");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== soc_io.f ====
hdl/soc_io_pkg.sv
hdl/bus_fabric.sv
hdl/scratch_ram.sv
hdl/prng_unit.sv
hdl/io_bridge.sv
hdl/video_reg_file.sv
hdl/soc_io_top.sv
testbench/soc_io_tb.sv

// ==== Bender.yml ====
package:
  name: soc_io

sources:
  - hdl/soc_io_pkg.sv
  - hdl/bus_fabric.sv
  - hdl/scratch_ram.sv
  - hdl/prng_unit.sv
  - hdl/io_bridge.sv
  - hdl/video_reg_file.sv
  - hdl/soc_io_top.sv
  - target: simulation
    files:
      - testbench/soc_io_tb.sv
